/* logic/dcache_bus_pkg.sv */
package dcache_bus_pkg;

	localparam int ADDRESS_BITS = 16; // byte address.
	localparam int DATA_BITS    = 32; // one word, also one block.

endpackage

/* logic/dcache_geometry_pkg.sv */
package dcache_geometry_pkg;

	import dcache_bus_pkg::*;

	localparam int WAYS        = 2;
	localparam int SETS        = 8;
	localparam int INDEX_BITS  = 3;
	localparam int OFFSET_BITS = 2; // ignored by the cache.
	localparam int TAG_BITS    = ADDRESS_BITS - INDEX_BITS - OFFSET_BITS;

	// control FSM encodings
	localparam int STATE_BITS                  = 3;
	localparam logic [2:0] STATE_IDLE          = 3'd0;
	localparam logic [2:0] STATE_LOOKUP        = 3'd1; // replay after a fill.
	localparam logic [2:0] STATE_WRITEBACK     = 3'd2;
	localparam logic [2:0] STATE_FETCH         = 3'd3;
	localparam logic [2:0] STATE_LOAD          = 3'd4;
	localparam logic [2:0] STATE_RESPOND       = 3'd5;

	// flat for memory, split for lookup.
	typedef union packed {
		logic [ADDRESS_BITS-1:0] flat;
		struct packed {
			logic [TAG_BITS-1:0]    tag;
			logic [INDEX_BITS-1:0]  index;
			logic [OFFSET_BITS-1:0] offset;
		} field;
	} cache_address_t;

endpackage

/* logic/dcache_set_entry.sv */
`timescale 1ns/1ps

module dcache_set_entry
	import dcache_bus_pkg::*, dcache_geometry_pkg::*;
(
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               read_value_enable,
	input  logic                               write_value_enable,
	input  logic                               load_value_enable,
	input  logic                               way_select,
	input  logic [TAG_BITS-1:0]                tag_in,
	input  logic [DATA_BITS-1:0]               data_in,
	output logic [DATA_BITS-1:0]               data_out,
	output logic                               hit,
	output logic                               hit_way,
	output logic [WAYS-1:0][TAG_BITS-1:0]      tag_out,
	output logic [WAYS-1:0]                    dirty_out,
	output logic [WAYS-1:0]                    valid_out,
	output logic                               way_out
);

	logic [WAYS-1:0][TAG_BITS-1:0]  tags;
	logic [WAYS-1:0][DATA_BITS-1:0] blocks;
	logic [WAYS-1:0]                valid;
	logic [WAYS-1:0]                dirty;
	logic                           lru; // names the next victim.
	logic [WAYS-1:0]                match;
	logic                           store;

	always_comb
	begin
		for (int i = 0; i < WAYS; i++)
		begin
			match[i] = valid[i] && (tags[i] == tag_in);
		end
	end

	assign hit      = |match;
	assign hit_way  = match[1];
	assign data_out = hit ? blocks[hit_way] : blocks[way_select]; // victim data on a miss.
	assign store    = write_value_enable || load_value_enable;

	assign tag_out   = tags;
	assign dirty_out = dirty;
	assign valid_out = valid;
	assign way_out   = lru;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= '0;
			dirty <= '0;
			lru   <= 1'b0;
		end
		else if (store)
		begin
			valid[way_select] <= 1'b1;
			dirty[way_select] <= write_value_enable; // a load leaves the block clean.
			lru               <= ~way_select;
		end
		else if (read_value_enable && hit)
		begin
			lru <= ~hit_way;
		end
	end

	always_ff @(posedge clock)
	begin
		if (store)
		begin
			tags[way_select]   <= tag_in;
			blocks[way_select] <= data_in;
		end
	end

endmodule

/* logic/dcache_request_stage.sv */
`timescale 1ns/1ps

module dcache_request_stage
	import dcache_bus_pkg::*, dcache_geometry_pkg::*;
(
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    cpu_read,
	input  logic                    cpu_write,
	input  logic [ADDRESS_BITS-1:0] cpu_address,
	input  logic [DATA_BITS-1:0]    cpu_write_data,
	input  logic                    busy,
	output logic                    request_valid,
	output logic                    request_write,
	output logic [TAG_BITS-1:0]     request_tag,
	output logic [INDEX_BITS-1:0]   request_index,
	output logic [DATA_BITS-1:0]    request_data
);

	cache_address_t address;
	logic           accept;

	assign address.flat = cpu_address;
	assign accept       = (cpu_read || cpu_write) && !busy; // strobes during busy are lost.

	always_ff @(posedge clock)
	begin
		if (reset)
			request_valid <= 1'b0;
		else
			request_valid <= accept;
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			request_write <= cpu_write; // write wins over read.
			request_tag   <= address.field.tag;
			request_index <= address.field.index;
			request_data  <= cpu_write_data;
		end
	end

endmodule

/* logic/dcache_tag_stage.sv */
`timescale 1ns/1ps

module dcache_tag_stage
	import dcache_bus_pkg::*, dcache_geometry_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic [INDEX_BITS-1:0] lookup_index,
	input  logic [TAG_BITS-1:0]   lookup_tag,
	input  logic                  read_enable,
	input  logic                  write_enable,
	input  logic                  load_enable,
	input  logic                  access_way,
	input  logic [DATA_BITS-1:0]  access_data,
	output logic                  lookup_hit,
	output logic                  hit_way,
	output logic [DATA_BITS-1:0]  hit_data,
	output logic                  victim_way,
	output logic                  victim_dirty,
	output logic [TAG_BITS-1:0]   victim_tag,
	output logic [DATA_BITS-1:0]  victim_data
);

	logic [SETS-1:0][DATA_BITS-1:0]           set_data;
	logic [SETS-1:0]                          set_hit;
	logic [SETS-1:0]                          set_hit_way;
	logic [SETS-1:0][WAYS-1:0][TAG_BITS-1:0]  set_tags;
	logic [SETS-1:0][WAYS-1:0]                set_dirty;
	logic [SETS-1:0][WAYS-1:0]                set_valid;
	logic [SETS-1:0]                          set_lru;
	logic [WAYS-1:0]                          valid_now;
	logic [DATA_BITS-1:0]                     data_now;

	for (genvar i = 0; i < SETS; i++)
	begin : g_set
		logic selected;

		assign selected = lookup_index == INDEX_BITS'(i);

		dcache_set_entry set_i (
			.clock              (clock),
			.reset              (reset),
			.read_value_enable  (read_enable && selected),
			.write_value_enable (write_enable && selected),
			.load_value_enable  (load_enable && selected),
			.way_select         (access_way),
			.tag_in             (lookup_tag),
			.data_in            (access_data),
			.data_out           (set_data[i]),
			.hit                (set_hit[i]),
			.hit_way            (set_hit_way[i]),
			.tag_out            (set_tags[i]),
			.dirty_out          (set_dirty[i]),
			.valid_out          (set_valid[i]),
			.way_out            (set_lru[i])
		);
	end

	assign valid_now  = set_valid[lookup_index];
	assign data_now   = set_data[lookup_index];
	assign lookup_hit = set_hit[lookup_index];
	assign hit_way    = set_hit_way[lookup_index];

	// empty ways go first, way 0 before way 1.
	always_comb
	begin
		if (!valid_now[0])
			victim_way = 1'b0;
		else if (!valid_now[1])
			victim_way = 1'b1;
		else
			victim_way = set_lru[lookup_index];
	end

	assign victim_dirty = set_dirty[lookup_index][victim_way];
	assign victim_tag   = set_tags[lookup_index][victim_way];
	assign hit_data     = lookup_hit ? data_now : '0;
	assign victim_data  = data_now; // set reads access_way on a miss.

endmodule

/* logic/dcache_control_stage.sv */
`timescale 1ns/1ps

module dcache_control_stage
	import dcache_bus_pkg::*, dcache_geometry_pkg::*;
(
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    request_valid,
	input  logic                    request_write,
	input  logic [TAG_BITS-1:0]     request_tag,
	input  logic [INDEX_BITS-1:0]   request_index,
	input  logic [DATA_BITS-1:0]    request_data,
	input  logic                    lookup_hit,
	input  logic                    hit_way,
	input  logic                    victim_way,
	input  logic                    victim_dirty,
	input  logic [TAG_BITS-1:0]     victim_tag,
	input  logic [DATA_BITS-1:0]    victim_data,
	input  logic [DATA_BITS-1:0]    hit_data,
	output logic                    read_enable,
	output logic                    write_enable,
	output logic                    load_enable,
	output logic                    access_way,
	output logic [DATA_BITS-1:0]    access_data,
	output logic [TAG_BITS-1:0]     lookup_tag,
	output logic [INDEX_BITS-1:0]   lookup_index,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic [ADDRESS_BITS-1:0] mem_address,
	output logic [DATA_BITS-1:0]    mem_write_data,
	input  logic                    mem_ready,
	input  logic [DATA_BITS-1:0]    mem_read_data,
	output logic [DATA_BITS-1:0]    cpu_read_data,
	output logic                    cpu_done,
	output logic                    busy
);

	logic [STATE_BITS-1:0] state;
	logic                  idle;
	logic                  fresh;
	logic                  complete;
	logic                  write_now;
	logic                  held_write;
	logic [TAG_BITS-1:0]   held_tag;
	logic [INDEX_BITS-1:0] held_index;
	logic [DATA_BITS-1:0]  held_data;
	logic [DATA_BITS-1:0]  fill_data;
	cache_address_t        victim_address;
	cache_address_t        fill_address;

	assign idle  = state == STATE_IDLE;
	assign fresh = idle && request_valid;

	// new requests look up straight from the request stage.
	assign lookup_tag   = idle ? request_tag : held_tag;
	assign lookup_index = idle ? request_index : held_index;
	assign write_now    = idle ? request_write : held_write;

	assign complete     = (fresh && lookup_hit) || (state == STATE_LOOKUP);
	assign read_enable  = complete && !write_now;
	assign write_enable = complete && write_now;
	assign load_enable  = state == STATE_LOAD;
	assign access_way   = lookup_hit ? hit_way : victim_way;
	assign access_data  = load_enable ? fill_data : (idle ? request_data : held_data);

	assign cpu_done = state == STATE_RESPOND;
	assign busy     = request_valid || !(idle || cpu_done);

	always_comb
	begin
		victim_address.field.tag    = victim_tag;
		victim_address.field.index  = lookup_index;
		victim_address.field.offset = '0;
		fill_address.field.tag      = lookup_tag;
		fill_address.field.index    = lookup_index;
		fill_address.field.offset   = '0;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state     <= STATE_IDLE;
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
		end
		else
		begin
			mem_read  <= 1'b0; // strobes last one cycle.
			mem_write <= 1'b0;
			case (state)
				STATE_IDLE:
					if (fresh && lookup_hit)
						state <= STATE_RESPOND;
					else if (fresh && victim_dirty)
					begin
						state     <= STATE_WRITEBACK;
						mem_write <= 1'b1;
					end
					else if (fresh)
					begin
						state    <= STATE_FETCH;
						mem_read <= 1'b1;
					end
				STATE_WRITEBACK:
					if (mem_ready)
					begin
						state    <= STATE_FETCH;
						mem_read <= 1'b1;
					end
				STATE_FETCH:
					if (mem_ready)
						state <= STATE_LOAD;
				STATE_LOAD:
					state <= STATE_LOOKUP;
				STATE_LOOKUP:
					state <= STATE_RESPOND;
				default:
					state <= STATE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (fresh)
		begin
			held_write <= request_write;
			held_tag   <= request_tag;
			held_index <= request_index;
			held_data  <= request_data;
		end
		if (fresh && !lookup_hit)
		begin
			mem_address    <= victim_dirty ? victim_address.flat : fill_address.flat;
			mem_write_data <= victim_data;
		end
		if (state == STATE_WRITEBACK && mem_ready)
			mem_address <= fill_address.flat;
		if (state == STATE_FETCH && mem_ready)
			fill_data <= mem_read_data;
		if (complete)
			cpu_read_data <= write_now ? access_data : hit_data; // writes echo their data.
	end

endmodule

/* logic/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
	import dcache_bus_pkg::*, dcache_geometry_pkg::*;
(
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    cpu_read,
	input  logic                    cpu_write,
	input  logic [ADDRESS_BITS-1:0] cpu_address,
	input  logic [DATA_BITS-1:0]    cpu_write_data,
	output logic [DATA_BITS-1:0]    cpu_read_data,
	output logic                    cpu_done,
	output logic                    busy,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic [ADDRESS_BITS-1:0] mem_address,
	output logic [DATA_BITS-1:0]    mem_write_data,
	input  logic                    mem_ready,
	input  logic [DATA_BITS-1:0]    mem_read_data
);

	logic                  request_valid;
	logic                  request_write;
	logic [TAG_BITS-1:0]   request_tag;
	logic [INDEX_BITS-1:0] request_index;
	logic [DATA_BITS-1:0]  request_data;
	logic                  lookup_hit;
	logic                  hit_way;
	logic [DATA_BITS-1:0]  hit_data;
	logic                  victim_way;
	logic                  victim_dirty;
	logic [TAG_BITS-1:0]   victim_tag;
	logic [DATA_BITS-1:0]  victim_data;
	logic                  read_enable;
	logic                  write_enable;
	logic                  load_enable;
	logic                  access_way;
	logic [DATA_BITS-1:0]  access_data;
	logic [TAG_BITS-1:0]   lookup_tag;
	logic [INDEX_BITS-1:0] lookup_index;

	dcache_request_stage request_i (
		.clock          (clock),
		.reset          (reset),
		.cpu_read       (cpu_read),
		.cpu_write      (cpu_write),
		.cpu_address    (cpu_address),
		.cpu_write_data (cpu_write_data),
		.busy           (busy),
		.request_valid  (request_valid),
		.request_write  (request_write),
		.request_tag    (request_tag),
		.request_index  (request_index),
		.request_data   (request_data)
	);

	dcache_tag_stage tag_i (
		.clock        (clock),
		.reset        (reset),
		.lookup_index (lookup_index),
		.lookup_tag   (lookup_tag),
		.read_enable  (read_enable),
		.write_enable (write_enable),
		.load_enable  (load_enable),
		.access_way   (access_way),
		.access_data  (access_data),
		.lookup_hit   (lookup_hit),
		.hit_way      (hit_way),
		.hit_data     (hit_data),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_data  (victim_data)
	);

	dcache_control_stage control_i (
		.clock          (clock),
		.reset          (reset),
		.request_valid  (request_valid),
		.request_write  (request_write),
		.request_tag    (request_tag),
		.request_index  (request_index),
		.request_data   (request_data),
		.lookup_hit     (lookup_hit),
		.hit_way        (hit_way),
		.victim_way     (victim_way),
		.victim_dirty   (victim_dirty),
		.victim_tag     (victim_tag),
		.victim_data    (victim_data),
		.hit_data       (hit_data),
		.read_enable    (read_enable),
		.write_enable   (write_enable),
		.load_enable    (load_enable),
		.access_way     (access_way),
		.access_data    (access_data),
		.lookup_tag     (lookup_tag),
		.lookup_index   (lookup_index),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_address    (mem_address),
		.mem_write_data (mem_write_data),
		.mem_ready      (mem_ready),
		.mem_read_data  (mem_read_data),
		.cpu_read_data  (cpu_read_data),
		.cpu_done       (cpu_done),
		.busy           (busy)
	);

endmodule

/* verification/dcache_memory_model.sv */
`timescale 1ns/1ps

module dcache_memory_model
	import dcache_bus_pkg::*;
(
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    mem_read,
	input  logic                    mem_write,
	input  logic [ADDRESS_BITS-1:0] mem_address,
	input  logic [DATA_BITS-1:0]    mem_write_data,
	output logic                    mem_ready,
	output logic [DATA_BITS-1:0]    mem_read_data
);

	localparam int REPLY_DELAY = 3;

	logic [DATA_BITS-1:0]    contents [logic [ADDRESS_BITS-1:0]]; // only words written so far.
	logic                    pending;
	logic                    pending_write;
	logic [ADDRESS_BITS-1:0] pending_address;
	logic [DATA_BITS-1:0]    pending_data;
	int                      countdown;

	function automatic logic [DATA_BITS-1:0] stored_word(input logic [ADDRESS_BITS-1:0] address);
		if (contents.exists(address))
			return contents[address];
		return DATA_BITS'(address) ^ 32'h5A5A0000; // untouched words.
	endfunction

	initial
	begin
		mem_ready     = 1'b0;
		mem_read_data = '0;
		pending       = 1'b0;
		countdown     = 0;
	end

	always @(posedge clock)
	begin
		mem_ready <= 1'b0;
		if (reset)
			pending <= 1'b0;
		else if (pending && countdown == 0)
		begin
			pending   <= 1'b0;
			mem_ready <= 1'b1;
			if (pending_write)
				contents[pending_address] = pending_data;
			else
				mem_read_data <= stored_word(pending_address);
		end
		else if (pending)
			countdown <= countdown - 1;
		else if (mem_read || mem_write)
		begin
			pending         <= 1'b1;
			pending_write   <= mem_write;
			pending_address <= mem_address;
			pending_data    <= mem_write_data;
			countdown       <= REPLY_DELAY - 1; // ready lands 3 edges after the strobe.
		end
	end

endmodule

/* verification/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb
	import dcache_bus_pkg::*, dcache_geometry_pkg::*;
();

	localparam int DONE_TIMEOUT = 200;

	logic                    clock;
	logic                    reset;
	logic                    cpu_read;
	logic                    cpu_write;
	logic [ADDRESS_BITS-1:0] cpu_address;
	logic [DATA_BITS-1:0]    cpu_write_data;
	logic [DATA_BITS-1:0]    cpu_read_data;
	logic                    cpu_done;
	logic                    busy;
	logic                    mem_read;
	logic                    mem_write;
	logic [ADDRESS_BITS-1:0] mem_address;
	logic [DATA_BITS-1:0]    mem_write_data;
	logic                    mem_ready;
	logic [DATA_BITS-1:0]    mem_read_data;

	logic [DATA_BITS-1:0]    expected_words [logic [ADDRESS_BITS-1:0]];
	logic [31:0]             random_state;
	logic [ADDRESS_BITS-1:0] last_write_address;
	logic [DATA_BITS-1:0]    last_write_data;
	int                      read_strobes;
	int                      write_strobes;
	int                      errors;
	int                      checks;
	int                      tests_run;
	int                      tests_failed;

	dcache_top dut_i (
		.clock          (clock),
		.reset          (reset),
		.cpu_read       (cpu_read),
		.cpu_write      (cpu_write),
		.cpu_address    (cpu_address),
		.cpu_write_data (cpu_write_data),
		.cpu_read_data  (cpu_read_data),
		.cpu_done       (cpu_done),
		.busy           (busy),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_address    (mem_address),
		.mem_write_data (mem_write_data),
		.mem_ready      (mem_ready),
		.mem_read_data  (mem_read_data)
	);

	dcache_memory_model memory_i (
		.clock          (clock),
		.reset          (reset),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_address    (mem_address),
		.mem_write_data (mem_write_data),
		.mem_ready      (mem_ready),
		.mem_read_data  (mem_read_data)
	);

	always
	begin
		#20 clock = ~clock; // 40 ns period.
	end

	// counts memory strobes and keeps the last writeback.
	always @(posedge clock)
	begin
		if (mem_read)
			read_strobes++;
		if (mem_write)
		begin
			write_strobes++;
			last_write_address = mem_address;
			last_write_data    = mem_write_data;
		end
	end

	function automatic logic [31:0] next_random();
		random_state = random_state * 32'd1664525 + 32'd1013904223;
		return random_state;
	endfunction

	function automatic logic [ADDRESS_BITS-1:0] make_address(input int tag, input int index);
		cache_address_t address;
		address.field.tag    = TAG_BITS'(tag);
		address.field.index  = INDEX_BITS'(index);
		address.field.offset = '0;
		return address.flat;
	endfunction

	function automatic logic [DATA_BITS-1:0] expected_word(input logic [ADDRESS_BITS-1:0] address);
		logic [ADDRESS_BITS-1:0] key;
		key = {address[ADDRESS_BITS-1:OFFSET_BITS], OFFSET_BITS'(0)}; // offset is ignored.
		if (expected_words.exists(key))
			return expected_words[key];
		return DATA_BITS'(key) ^ 32'h5A5A0000;
	endfunction

	task automatic check_value(input string name, input logic [DATA_BITS-1:0] actual,
			input logic [DATA_BITS-1:0] expected);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("mismatch %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$finish;
	endtask

	task automatic wait_done(output int latency);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (!cpu_done && cycles < DONE_TIMEOUT);
		if (!cpu_done)
			abort_run("timed out waiting for cpu_done from the cache");
		else
			latency = cycles;
	endtask

	// latency counts cycles from the accepting edge to cpu_done.
	task automatic cache_access(input logic write, input logic [ADDRESS_BITS-1:0] address,
			input logic [DATA_BITS-1:0] data, output logic [DATA_BITS-1:0] result,
			output int latency);
		@(posedge clock);
		cpu_read       <= !write;
		cpu_write      <= write;
		cpu_address    <= address;
		cpu_write_data <= data;
		@(posedge clock);
		cpu_read       <= 1'b0;
		cpu_write      <= 1'b0;
		wait_done(latency);
		result = cpu_read_data;
		check_value("busy", busy, 1'b0);
		if (write)
			expected_words[make_address(address >> (INDEX_BITS + OFFSET_BITS),
				address[INDEX_BITS+OFFSET_BITS-1:OFFSET_BITS])] = data;
	endtask

	task automatic read_checked(input logic [ADDRESS_BITS-1:0] address, output int latency);
		logic [DATA_BITS-1:0] expected;
		logic [DATA_BITS-1:0] result;
		expected = expected_word(address);
		cache_access(1'b0, address, '0, result, latency);
		check_value("cpu_read_data", result, expected);
	endtask

	task automatic write_word(input logic [ADDRESS_BITS-1:0] address,
			input logic [DATA_BITS-1:0] data, output int latency);
		logic [DATA_BITS-1:0] result;
		cache_access(1'b1, address, data, result, latency);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("test %0d, %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d, %s: %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	initial
	begin
		int                      latency;
		int                      errors_before;
		int                      reads_before;
		int                      writes_before;
		logic [ADDRESS_BITS-1:0] address;
		logic [ADDRESS_BITS-1:0] address_a;
		logic [ADDRESS_BITS-1:0] address_b;
		logic [ADDRESS_BITS-1:0] address_c;
		logic [31:0]             value;

		clock          = 1'b0;
		reset          = 1'b1;
		cpu_read       = 1'b0;
		cpu_write      = 1'b0;
		cpu_address    = '0;
		cpu_write_data = '0;
		random_state   = 32'd69333;
		read_strobes   = 0;
		write_strobes  = 0;
		errors         = 0;
		checks         = 0;
		tests_run      = 0;
		tests_failed   = 0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		errors_before = errors;
		@(negedge clock);
		check_value("busy", busy, 1'b0);
		check_value("cpu_done", cpu_done, 1'b0);
		check_value("mem_read", mem_read, 1'b0);
		check_value("mem_write", mem_write, 1'b0);
		reads_before = read_strobes;
		read_checked(make_address(1, 0), latency);
		check_value("mem_read count", read_strobes - reads_before, 1);
		finish_test("reset state and first read", errors_before);

		errors_before = errors;
		address       = make_address(11'h02a, 1);
		reads_before  = read_strobes;
		read_checked(address, latency);
		check_value("mem_read count", read_strobes - reads_before, 1);
		reads_before  = read_strobes;
		writes_before = write_strobes;
		read_checked(address, latency);
		check_value("mem_read count", read_strobes - reads_before, 0);
		check_value("mem_write count", write_strobes - writes_before, 0);
		check_value("cpu_done latency", latency, 2);
		finish_test("read miss then read hit", errors_before);

		errors_before = errors;
		address       = make_address(11'h033, 2);
		read_checked(address, latency);
		reads_before  = read_strobes;
		writes_before = write_strobes;
		write_word(address, 32'hC0FFEE01, latency);
		check_value("cpu_done latency", latency, 2);
		read_checked(address, latency);
		check_value("mem_read count", read_strobes - reads_before, 0);
		check_value("mem_write count", write_strobes - writes_before, 0);
		finish_test("write hit then read", errors_before);

		// three tags fight over set 5.
		errors_before = errors;
		address_a     = make_address(11'h101, 5);
		address_b     = make_address(11'h102, 5);
		address_c     = make_address(11'h103, 5);
		writes_before = write_strobes;
		write_word(address_a, 32'hA5A50001, latency);
		read_checked(address_b, latency);
		read_checked(address_a, latency);
		check_value("cpu_done latency", latency, 2);
		reads_before  = read_strobes;
		read_checked(address_c, latency);
		check_value("mem_read count", read_strobes - reads_before, 1);
		check_value("mem_write count", write_strobes - writes_before, 0);
		read_checked(address_b, latency);
		check_value("mem_write count", write_strobes - writes_before, 1);
		check_value("mem_address", last_write_address, address_a);
		check_value("mem_write_data", last_write_data, 32'hA5A50001);
		read_checked(address_a, latency);
		finish_test("eviction and writeback", errors_before);

		errors_before = errors;
		for (int i = 0; i < 200; i++)
		begin
			value   = next_random();
			address = {8'h40, value[21:16], value[25:24]}; // 64 words over 8 sets.
			if (value[28])
				write_word(address, next_random(), latency);
			else
				read_checked(address, latency);
		end
		finish_test("random mix of 200 accesses", errors_before);

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* verilog.f */
logic/dcache_bus_pkg.sv
logic/dcache_geometry_pkg.sv
logic/dcache_set_entry.sv
logic/dcache_request_stage.sv
logic/dcache_tag_stage.sv
logic/dcache_control_stage.sv
logic/dcache_top.sv
verification/dcache_memory_model.sv
verification/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - logic/dcache_bus_pkg.sv
  - logic/dcache_geometry_pkg.sv
  - logic/dcache_set_entry.sv
  - logic/dcache_request_stage.sv
  - logic/dcache_tag_stage.sv
  - logic/dcache_control_stage.sv
  - logic/dcache_top.sv
  - target: simulation
    files:
      - verification/dcache_memory_model.sv
      - verification/dcache_tb.sv
